// File: source/sha3_cfg_pkg.sv
// SHA3 padding configuration
// Data widths, mode and strength encodings, the rate table and pad bytes

package sha3_cfg_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // One message beat is a 64-bit lane of the Keccak state
  localparam int msg_width   = 64;
  localparam int msg_strb_w  = msg_width / 8;
  // 25 lanes make up the 1600-bit state
  localparam int block_words = 25;
  localparam int word_addr_w = 5;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic {
    sha3,
    shake
  } sha3_mode_e;

  typedef enum logic [2:0] {
    l128,
    l224,
    l256,
    l384,
    l512
  } strength_e;

  // Source of the next buffer write
  typedef enum logic [1:0] {
    sel_none,
    sel_message,
    sel_suffix,
    sel_zero_end
  } word_sel_e;

  // Domain suffix with the first pad10*1 bit already folded in
  localparam logic [7:0] suffix_sha3  = 8'h06;
  localparam logic [7:0] suffix_shake = 8'h1f;
  // Closing bit of pad10*1, top bit of the last rate byte
  localparam logic [7:0] end_bit_byte = 8'h80;

  // Rate in 64-bit lanes for each strength
  function automatic logic [word_addr_w-1:0] rate_words(strength_e strength);
    unique case (strength)
      l128:    rate_words = word_addr_w'(21);
      l224:    rate_words = word_addr_w'(18);
      l256:    rate_words = word_addr_w'(17);
      l384:    rate_words = word_addr_w'(13);
      // Fall back to the smallest rate
      default: rate_words = word_addr_w'(9);
    endcase
  endfunction

endpackage

// File: source/sha3_pad_types_pkg.sv
// SHA3 padding bundles
// Packed structs passed between the padding blocks

package sha3_pad_types_pkg;

  // Message beat with byte strobes, 72 bits
  typedef struct packed {
    logic [sha3_cfg_pkg::msg_width-1:0]  data;
    logic [sha3_cfg_pkg::msg_strb_w-1:0] strb;
  } msg_beat_t;

  // One lane write into the block buffer, 70 bits
  typedef struct packed {
    logic                                 we;
    logic [sha3_cfg_pkg::word_addr_w-1:0] addr;
    logic [sha3_cfg_pkg::msg_width-1:0]   data;
  } word_write_t;

  // Position of the write counter relative to the rate
  typedef struct packed {
    logic block_full;
    logic last_word;
  } block_flags_t;

endpackage

// File: source/block_word_counter.sv
// Block word counter
// Counts lanes written in the current block and flags the rate limit

module block_word_counter (
  input  logic                                 clk_i,
  input  logic                                 rst_b,
  input  sha3_cfg_pkg::strength_e              strength_i,
  input  logic                                 inc_i,
  input  logic                                 clr_i,
  output logic [sha3_cfg_pkg::word_addr_w-1:0] word_addr_o,
  output sha3_pad_types_pkg::block_flags_t     flags_o
);
  import sha3_cfg_pkg::*;

  logic [word_addr_w-1:0] cnt_q;
  logic [word_addr_w-1:0] cnt_next;
  logic [word_addr_w-1:0] rate;

  // Rate limit for the selected strength
  assign rate     = rate_words(strength_i);
  assign cnt_next = cnt_q + 1'b1;

  // Clear takes priority so a new block always starts at lane 0
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (inc_i) begin
      cnt_q <= cnt_next;
    end
  end

  // Count doubles as the next write address
  assign word_addr_o = cnt_q;

  // Rate reached, and one lane left
  assign flags_o.block_full = (cnt_q == rate);
  assign flags_o.last_word  = (cnt_next == rate);

endmodule

// File: source/absorb_word_gen.sv
// Absorb word generator
// Holds a partial final beat and builds the lane written to the block
// buffer from the message, the merged suffix or the zero fill

module absorb_word_gen (
  input  logic                                 clk_i,
  input  logic                                 rst_b,
  input  sha3_cfg_pkg::sha3_mode_e             mode_i,
  input  sha3_pad_types_pkg::msg_beat_t        msg_i,
  input  sha3_cfg_pkg::word_sel_e              word_sel_i,
  input  logic                                 latch_partial_i,
  input  logic                                 clr_partial_i,
  input  logic [sha3_cfg_pkg::word_addr_w-1:0] word_addr_i,
  input  sha3_pad_types_pkg::block_flags_t     flags_i,
  output sha3_pad_types_pkg::word_write_t      wr_o
);
  import sha3_cfg_pkg::*;

  // A partial beat never has its top byte, so 7 bytes are enough
  logic [msg_width-9:0]  part_data_q;
  logic [msg_strb_w-2:0] part_strb_q;
  logic [msg_width-1:0]  data_ext;
  logic [msg_strb_w-1:0] strb_ext;
  logic [msg_strb_w-1:0] prev_ext;
  logic [7:0]            suffix_byte;
  logic [msg_width-1:0]  end_word;
  logic [msg_width-1:0]  suffix_word;

  ////////////////////
  // Partial beat
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (latch_partial_i) begin
      part_data_q <= msg_i.data[msg_width-9:0];
    end
  end

  // Strobes qualify the held data
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      part_strb_q <= '0;
    end else if (clr_partial_i) begin
      part_strb_q <= '0;
    end else if (latch_partial_i) begin
      part_strb_q <= msg_i.strb[msg_strb_w-2:0];
    end
  end

  ////////////////////
  // Lane formation
  ////////////////////

  assign suffix_byte = (mode_i == sha3) ? suffix_sha3 : suffix_shake;

  // End bit of pad10*1 lands only in the last lane of the rate
  assign end_word = flags_i.last_word ? {end_bit_byte, {(msg_width - 8){1'b0}}} : '0;

  // prev_ext[i] is set when byte i-1 is filled, byte 0 always qualifies
  assign data_ext = {8'h00, part_data_q};
  assign strb_ext = {1'b0, part_strb_q};
  assign prev_ext = {part_strb_q, 1'b1};

  // Held bytes first, the suffix in the first free byte, zero above
  always_comb begin
    suffix_word = '0;
    for (int i = 0; i < msg_strb_w; i++) begin
      if (strb_ext[i]) begin
        suffix_word[8*i +: 8] = data_ext[8*i +: 8];
      end else if (prev_ext[i]) begin
        suffix_word[8*i +: 8] = suffix_byte;
      end
    end
  end

  always_comb begin
    // Never write beyond the rate
    wr_o.we   = (word_sel_i != sel_none) && !flags_i.block_full;
    wr_o.addr = word_addr_i;
    unique case (word_sel_i)
      sel_message:  wr_o.data = msg_i.data;
      sel_suffix:   wr_o.data = suffix_word | end_word;
      sel_zero_end: wr_o.data = end_word;
      default:      wr_o.data = '0;
    endcase
  end

endmodule

// File: source/block_buffer.sv
// Keccak block buffer
// 25-lane register file filled one lane per cycle and presented whole
// to the permutation

module block_buffer (
  input  logic                                clk_i,
  input  logic                                rst_b,
  input  sha3_pad_types_pkg::word_write_t     wr_i,
  input  logic                                clr_i,
  output logic [sha3_cfg_pkg::block_words-1:0][sha3_cfg_pkg::msg_width-1:0] data_o
);
  import sha3_cfg_pkg::*;

  logic [block_words-1:0][msg_width-1:0] words_q;
  logic                                  wr_in_range;

  // Addresses past lane 24 are dropped
  assign wr_in_range = (wr_i.addr < word_addr_w'(block_words));

  ////////////////////
  // Storage
  ////////////////////

  // Lanes above the rate stay zero since only clears touch them
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      words_q <= '0;
    end else if (clr_i) begin
      // New block starts from an all-zero state input
      words_q <= '0;
    end else if (wr_i.we && wr_in_range) begin
      words_q[wr_i.addr] <= wr_i.data;
    end
  end

  // Whole state presented to Keccak
  assign data_o = words_q;

endmodule

// File: source/pad_ctrl.sv
// Padding control FSM
// Accepts message beats, triggers Keccak on each full block, then writes
// the suffix and zero fill and reports absorbed after the final block

module pad_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_b,
  input  logic                             zeroize_i,
  input  logic                             start_i,
  input  logic                             process_i,
  input  logic                             msg_valid_i,
  input  sha3_pad_types_pkg::msg_beat_t    msg_i,
  input  logic                             keccak_complete_i,
  input  sha3_pad_types_pkg::block_flags_t flags_i,
  output logic                             msg_ready_o,
  output sha3_cfg_pkg::word_sel_e          word_sel_o,
  output logic                             cnt_inc_o,
  output logic                             cnt_clr_o,
  output logic                             buf_clr_o,
  output logic                             latch_partial_o,
  output logic                             clr_partial_o,
  output logic                             keccak_run_o,
  output logic                             absorbed_o
);
  import sha3_cfg_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_message,
    st_block_run,
    st_block_wait,
    st_suffix,
    st_zero_fill,
    st_final_run,
    st_final_wait
  } pad_st_e;

  pad_st_e st_q;
  pad_st_e st_d;
  logic    process_q;
  logic    absorbed_d;
  logic    msg_partial;
  logic    accept;

  ////////////////////
  // Inputs
  ////////////////////

  // Any cleared strobe marks the closing partial beat
  assign msg_partial = ~&msg_i.strb;

  // No beats while a block is full, a process request is pending or on zeroize
  assign msg_ready_o = (st_q == st_message) & ~process_q & ~flags_i.block_full & ~zeroize_i;
  assign accept      = msg_valid_i & msg_ready_o;

  // Keeps a process pulse that lands while a block is still with Keccak
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      process_q <= 1'b0;
    end else if (zeroize_i || start_i) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end
  end

  ////////////////////
  // State machine
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q       <= st_idle;
      absorbed_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  always_comb begin
    st_d            = st_q;
    word_sel_o      = sel_none;
    cnt_inc_o       = 1'b0;
    cnt_clr_o       = 1'b0;
    buf_clr_o       = 1'b0;
    latch_partial_o = 1'b0;
    clr_partial_o   = 1'b0;
    keccak_run_o    = 1'b0;
    absorbed_d      = 1'b0;

    unique case (st_q)
      st_idle: begin
        if (start_i) begin
          st_d = st_message;
        end
      end

      st_message: begin
        if (accept && msg_partial) begin
          // Held back until the suffix write
          latch_partial_o = 1'b1;
        end else if (accept) begin
          word_sel_o = sel_message;
          cnt_inc_o  = 1'b1;
          // This beat completes the rate
          if (flags_i.last_word) begin
            st_d = st_block_run;
          end
        end else if (process_q) begin
          st_d = st_suffix;
        end
      end

      st_block_run: begin
        keccak_run_o = 1'b1;
        st_d         = st_block_wait;
      end

      // Buffer frozen until the permutation is done
      st_block_wait: begin
        if (keccak_complete_i) begin
          cnt_clr_o = 1'b1;
          buf_clr_o = 1'b1;
          st_d      = st_message;
        end
      end

      // Partial bytes merged with the domain suffix
      st_suffix: begin
        word_sel_o    = sel_suffix;
        cnt_inc_o     = 1'b1;
        clr_partial_o = 1'b1;
        st_d          = flags_i.last_word ? st_final_run : st_zero_fill;
      end

      st_zero_fill: begin
        word_sel_o = sel_zero_end;
        cnt_inc_o  = 1'b1;
        if (flags_i.last_word) begin
          st_d = st_final_run;
        end
      end

      st_final_run: begin
        keccak_run_o = 1'b1;
        st_d         = st_final_wait;
      end

      st_final_wait: begin
        if (keccak_complete_i) begin
          cnt_clr_o  = 1'b1;
          buf_clr_o  = 1'b1;
          absorbed_d = 1'b1;
          st_d       = st_idle;
        end
      end

      default: begin
        st_d = st_idle;
      end
    endcase

    // Zeroize wins over everything and wipes the datapath
    if (zeroize_i) begin
      st_d            = st_idle;
      word_sel_o      = sel_none;
      cnt_inc_o       = 1'b0;
      latch_partial_o = 1'b0;
      keccak_run_o    = 1'b0;
      absorbed_d      = 1'b0;
      cnt_clr_o       = 1'b1;
      buf_clr_o       = 1'b1;
      clr_partial_o   = 1'b1;
    end
  end

endmodule

// File: source/sha3_pad.sv
// SHA3/SHAKE padding unit
// Packs message beats into the Keccak block buffer, appends the domain
// suffix and pad10*1, and hands each full block to the permutation

module sha3_pad (
  input  logic                                    clk_i,
  input  logic                                    rst_b,
  input  logic                                    zeroize_i,
  input  logic                                    msg_valid_i,
  input  sha3_pad_types_pkg::msg_beat_t           msg_i,
  output logic                                    msg_ready_o,
  input  logic                                    start_i,
  input  logic                                    process_i,
  input  sha3_cfg_pkg::sha3_mode_e                mode_i,
  input  sha3_cfg_pkg::strength_e                 strength_i,
  output logic [sha3_cfg_pkg::block_words-1:0][sha3_cfg_pkg::msg_width-1:0] keccak_data_o,
  output logic                                    keccak_run_o,
  input  logic                                    keccak_complete_i,
  output logic                                    absorbed_o
);
  import sha3_cfg_pkg::*;
  import sha3_pad_types_pkg::*;

  // Control from the FSM
  word_sel_e              word_sel;
  logic                   cnt_inc;
  logic                   cnt_clr;
  logic                   buf_clr;
  logic                   latch_partial;
  logic                   clr_partial;
  // Counter status
  block_flags_t           flags;
  logic [word_addr_w-1:0] word_addr;
  // Lane write into the buffer
  word_write_t            wr;

  pad_ctrl i_pad_ctrl (
    .clk_i,
    .rst_b,
    .zeroize_i,
    .start_i,
    .process_i,
    .msg_valid_i,
    .msg_i,
    .keccak_complete_i,
    .flags_i         (flags),
    .msg_ready_o,
    .word_sel_o      (word_sel),
    .cnt_inc_o       (cnt_inc),
    .cnt_clr_o       (cnt_clr),
    .buf_clr_o       (buf_clr),
    .latch_partial_o (latch_partial),
    .clr_partial_o   (clr_partial),
    .keccak_run_o,
    .absorbed_o
  );

  block_word_counter i_block_word_counter (
    .clk_i,
    .rst_b,
    .strength_i,
    .inc_i       (cnt_inc),
    .clr_i       (cnt_clr),
    .word_addr_o (word_addr),
    .flags_o     (flags)
  );

  absorb_word_gen i_absorb_word_gen (
    .clk_i,
    .rst_b,
    .mode_i,
    .msg_i,
    .word_sel_i      (word_sel),
    .latch_partial_i (latch_partial),
    .clr_partial_i   (clr_partial),
    .word_addr_i     (word_addr),
    .flags_i         (flags),
    .wr_o            (wr)
  );

  block_buffer i_block_buffer (
    .clk_i,
    .rst_b,
    .wr_i   (wr),
    .clr_i  (buf_clr),
    .data_o (keccak_data_o)
  );

endmodule

// File: bench/sha3_pad_assertions.sv
// SHA3 padding interface checks
// Pulse widths of run and absorbed, and back-pressure during a run

module sha3_pad_assertions (
  input logic clk_i,
  input logic rst_b,
  input logic msg_ready_i,
  input logic keccak_run_i,
  input logic absorbed_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failure tallies, one per rule
  int run_fail_cnt   = 0;
  int abs_fail_cnt   = 0;
  int ready_fail_cnt = 0;

  // Run is a single-cycle pulse
  run_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_b)
    keccak_run_i |=> !keccak_run_i)
  else begin
    run_fail_cnt = run_fail_cnt + 1;
    $error("keccak_run_o stayed high for more than one cycle");
  end

  // Absorbed is a single-cycle pulse
  absorbed_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_b)
    absorbed_i |=> !absorbed_i)
  else begin
    abs_fail_cnt = abs_fail_cnt + 1;
    $error("absorbed_o stayed high for more than one cycle");
  end

  // No beat may enter while the block goes to Keccak
  ready_low_in_run: assert property (@(posedge clk_i) disable iff (!rst_b)
    keccak_run_i |-> !msg_ready_i)
  else begin
    ready_fail_cnt = ready_fail_cnt + 1;
    $error("msg_ready_o was high in a run cycle");
  end

endmodule

bind sha3_pad sha3_pad_assertions i_sha3_pad_assertions (
  .clk_i        (clk_i),
  .rst_b        (rst_b),
  .msg_ready_i  (msg_ready_o),
  .keccak_run_i (keccak_run_o),
  .absorbed_i   (absorbed_o)
);

// File: bench/tb_sha3_pad.sv
// Testbench for the SHA3/SHAKE padding unit
// Drives messages, answers run pulses as a Keccak model and compares
// every block against a byte-level pad10*1 reference

module tb_sha3_pad;
  timeunit 1ns;
  timeprecision 1ps;
  import sha3_cfg_pkg::*;
  import sha3_pad_types_pkg::*;

  typedef logic [block_words-1:0][msg_width-1:0] block_t;

  localparam int clk_period      = 40;
  localparam int drive_delay     = 2;
  localparam int max_resp_cycles = 8;

  logic       clk_i;
  logic       rst_b;
  logic       zeroize_i;
  logic       msg_valid_i;
  msg_beat_t  msg_i;
  logic       msg_ready_o;
  logic       start_i;
  logic       process_i;
  sha3_mode_e mode_i;
  strength_e  strength_i;
  block_t     keccak_data_o;
  logic       keccak_run_o;
  logic       keccak_complete_i;
  logic       absorbed_o;

  // Current message and its expected blocks
  logic [7:0] msg_bytes[$];
  block_t     exp_blocks[$];
  string      test_name;
  int         run_cnt;
  int         run_base;
  int         absorbed_cnt;
  int         absorbed_base;
  int         cycle_cnt;
  int         deadline;

  sha3_pad i_sha3_pad (.*);

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic int rate_of(strength_e strength);
    case (strength)
      l128:    rate_of = 21;
      l224:    rate_of = 18;
      l256:    rate_of = 17;
      l384:    rate_of = 13;
      default: rate_of = 9;
    endcase
  endfunction

  // Block blk of message, suffix, zero fill, 0x80 in the last byte
  function automatic block_t ref_block(int blk, int rate, logic [7:0] sfx);
    block_t     blk_v;
    int         len;
    int         total;
    int         k;
    logic [7:0] val;
    blk_v = '0;
    len   = msg_bytes.size();
    total = (len / (rate * 8) + 1) * rate * 8;
    for (int w = 0; w < rate; w++) begin
      for (int b = 0; b < 8; b++) begin
        k = (blk * rate + w) * 8 + b;
        if (k < len) begin
          val = msg_bytes[k];
        end else if (k == len) begin
          val = sfx;
        end else begin
          val = 8'h00;
        end
        if (k == total - 1) begin
          val = val | 8'h80;
        end
        blk_v[w][8*b +: 8] = val;
      end
    end
    return blk_v;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_block(string name, block_t exp, block_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      abort_run($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  // Block contents sampled mid-cycle at each run pulse
  initial begin
    int idx;
    run_cnt      = 0;
    absorbed_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (rst_b && keccak_run_o) begin
        idx     = run_cnt - run_base;
        run_cnt = run_cnt + 1;
        if (idx >= exp_blocks.size()) begin
          abort_run($sformatf("Unexpected extra run pulse in %s", test_name));
        end else begin
          check_block($sformatf("%s block %0d", test_name, idx), exp_blocks[idx],
                      keccak_data_o);
        end
      end else if (rst_b && absorbed_o) begin
        absorbed_cnt = absorbed_cnt + 1;
        check_count({test_name, " run count"}, exp_blocks.size(), run_cnt - run_base);
      end
    end
  end

  // Keccak model, completion 1 to 8 cycles after each run
  initial begin
    int resp_wait;
    keccak_complete_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_b && keccak_run_o) begin
        resp_wait = 1 + int'($urandom % max_resp_cycles);
        repeat (resp_wait) @(posedge clk_i);
        #drive_delay;
        keccak_complete_i = 1'b1;
        @(posedge clk_i);
        #drive_delay;
        keccak_complete_i = 1'b0;
      end
    end
  end

  // Watchdog against a deadline set per message
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > deadline) begin
        abort_run($sformatf("Timeout: %s did not finish in time", test_name));
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Random message, expected blocks, then the start pulse
  task automatic setup_message(string name, sha3_mode_e mode, strength_e strength,
                               int len, int max_gap);
    int         rate;
    int         nblk;
    logic [7:0] sfx;
    rate = rate_of(strength);
    sfx  = (mode == sha3) ? 8'h06 : 8'h1f;
    nblk = len / (rate * 8) + 1;
    test_name = name;
    msg_bytes.delete();
    for (int i = 0; i < len; i++) begin
      msg_bytes.push_back(8'($urandom));
    end
    exp_blocks.delete();
    for (int b = 0; b < nblk; b++) begin
      exp_blocks.push_back(ref_block(b, rate, sfx));
    end
    run_base      = run_cnt;
    absorbed_base = absorbed_cnt;
    // Beats with gaps, plus fill, run and wait per block
    deadline = cycle_cnt + (len / 8 + 2) * (max_gap + 2)
               + nblk * (rate + max_resp_cycles + 6) + 20;
    mode_i     = mode;
    strength_i = strength;
    start_i    = 1'b1;
    @(posedge clk_i);
    #drive_delay;
    start_i = 1'b0;
  endtask

  // Holds a beat until the edge where ready is seen high
  task automatic drive_beat(msg_beat_t beat);
    msg_valid_i = 1'b1;
    msg_i       = beat;
    @(negedge clk_i);
    while (!msg_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #drive_delay;
    msg_valid_i = 1'b0;
    msg_i       = '0;
  endtask

  task automatic send_beats(int count, int max_gap);
    msg_beat_t beat;
    int        nbytes;
    int        gap;
    for (int i = 0; i < count; i++) begin
      nbytes = msg_bytes.size() - 8 * i;
      if (nbytes > 8) begin
        nbytes = 8;
      end
      beat = '0;
      for (int b = 0; b < nbytes; b++) begin
        beat.data[8*b +: 8] = msg_bytes[8*i + b];
        beat.strb[b]        = 1'b1;
      end
      gap = int'($urandom % (max_gap + 1));
      if (gap > 0) begin
        repeat (gap) @(posedge clk_i);
        #drive_delay;
      end
      drive_beat(beat);
    end
  endtask

  // Process pulse, then exactly one absorbed pulse
  task automatic finish_message();
    process_i = 1'b1;
    @(posedge clk_i);
    #drive_delay;
    process_i = 1'b0;
    while (absorbed_cnt == absorbed_base) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    #drive_delay;
    check_count({test_name, " absorbed pulses"}, 1, absorbed_cnt - absorbed_base);
  endtask

  task automatic run_message(string name, sha3_mode_e mode, strength_e strength,
                             int len, int max_gap);
    setup_message(name, mode, strength, len, max_gap);
    send_beats((len + 7) / 8, max_gap);
    finish_message();
  endtask

  initial begin
    strength_e  strengths[5];
    sha3_mode_e mode;
    int         rate;
    int         len;
    int         sel;
    void'($urandom(69));
    strengths   = '{l128, l224, l256, l384, l512};
    deadline    = 100;
    test_name   = "reset";
    run_base    = 0;
    rst_b       = 1'b0;
    zeroize_i   = 1'b0;
    msg_valid_i = 1'b0;
    msg_i       = '0;
    start_i     = 1'b0;
    process_i   = 1'b0;
    mode_i      = sha3;
    strength_i  = l256;
    repeat (2) @(posedge clk_i);
    #drive_delay;
    rst_b = 1'b1;
    @(posedge clk_i);
    #drive_delay;

    run_message("sha3_256_empty", sha3, l256, 0, 0);
    run_message("shake128_one_rate", shake, l128, 21 * 8, 0);

    // Partial last beat in every strength and mode
    for (int s = 0; s < 5; s++) begin
      for (int m = 0; m < 2; m++) begin
        mode = (m == 0) ? sha3 : shake;
        rate = rate_of(strengths[s]);
        len  = int'($urandom % (2 * rate)) * 8 + 1 + int'($urandom % 7);
        run_message($sformatf("partial_merge_s%0d_m%0d", s, m), mode, strengths[s], len, 1);
      end
    end

    // 7-byte partial in the last lane puts the suffix in the last byte
    for (int m = 0; m < 2; m++) begin
      mode = (m == 0) ? sha3 : shake;
      run_message($sformatf("suffix_last_byte_l512_m%0d", m), mode, l512, 9 * 8 - 1, 0);
      run_message($sformatf("suffix_last_byte_l128_m%0d", m), mode, l128, 21 * 8 - 1, 0);
    end

    // Random gaps, strengths and lengths
    for (int n = 0; n < 6; n++) begin
      sel  = int'($urandom % 5);
      mode = ($urandom % 2 == 0) ? sha3 : shake;
      len  = int'($urandom % (3 * rate_of(strengths[sel]) * 8 + 1));
      run_message($sformatf("random_gaps_%0d", n), mode, strengths[sel], len, 4);
    end

    // Zeroize with lanes filled well past the rate of the next message
    setup_message("zeroize_partial", sha3, l128, 20 * 8, 0);
    send_beats(20, 0);
    zeroize_i = 1'b1;
    @(posedge clk_i);
    #drive_delay;
    zeroize_i = 1'b0;
    @(negedge clk_i);
    if (msg_ready_o) begin
      abort_run("Unit still accepted beats after zeroize");
    end
    @(posedge clk_i);
    #drive_delay;
    // Lanes 9 to 19 only return to zero through the zeroize clear
    run_message("after_zeroize", shake, l512, 50, 2);

    if (i_sha3_pad.i_sha3_pad_assertions.run_fail_cnt
        + i_sha3_pad.i_sha3_pad_assertions.abs_fail_cnt
        + i_sha3_pad.i_sha3_pad_assertions.ready_fail_cnt != 0) begin
      abort_run("Interface assertions failed during the run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// File: compile.f
source/sha3_cfg_pkg.sv
source/sha3_pad_types_pkg.sv
source/block_word_counter.sv
source/absorb_word_gen.sv
source/block_buffer.sv
source/pad_ctrl.sv
source/sha3_pad.sv
bench/sha3_pad_assertions.sv
bench/tb_sha3_pad.sv

// File: Makefile
# Verilator build and run for the SHA3/SHAKE padding unit testbench

VERILATOR ?= verilator
TOP       ?= tb_sha3_pad
MDIR      ?= obj_dir
LOG       ?= sim.log
FLIST     ?= compile.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(wildcard source/*.sv) $(wildcard bench/*.sv)
BIN  := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "Simulation ended without passing"; exit 1; }

clean:
	rm -rf $(MDIR) $(LOG)
